//--- Makefile
# Verilator build, run and lint for the I3C transmit controller

VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= tb_i3c_controller
RTL_TOP   ?= i3c_controller
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only -Wall i3c_timing_pkg.sv i3c_bus_pkg.sv scl_timer.sv \
	  tx_shifter.sv bus_sequencer.sv i3c_controller.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bus_sequencer.sv
// Bus sequencer FSM: START, Sr, eight data bits, ninth bit and STOP on SCL/SDA
`timescale 1ns/1ps

module bus_sequencer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        host_enable_i,
  input  logic                        tx_valid_i,
  input  logic                        tx_start_i,     // START before the byte
  input  logic                        tx_stop_i,      // STOP after the byte
  input  logic                        tx_sr_i,        // Repeated Start before the byte
  input  logic                        tx_is_addr_i,   // Ninth bit is the target ACK
  input  logic                        tx_use_tbit_i,  // Ninth bit is a driven-low T-bit
  input  logic                        expired_i,
  input  logic                        data_bit_i,
  input  logic                        last_bit_i,
  input  logic                        ack_seen_i,
  output logic                        load_o,
  output i3c_timing_pkg::phase_sel_e  phase_sel_o,
  output logic                        load_byte_o,
  output logic                        bit_next_o,
  output logic                        sample_ack_o,
  output logic                        scl_o,
  output logic                        sda_o,
  output logic                        host_idle_o,
  output logic                        tx_ready_o,
  output logic                        tx_done_o,      // Last cycle of ack_hold
  output logic                        rx_ack_o,
  output logic                        rx_nack_o
);
  import i3c_timing_pkg::*;
  import i3c_bus_pkg::*;

  seq_state_e state_q, state_d;
  logic       accept;     // Byte taken in idle
  logic       advance;    // Phase over, bus not stalled
  logic       stop_q;
  logic       is_addr_q;
  logic       use_tbit_q;
  logic       ninth_sda;

  assign accept  = (state_q == idle) && tx_valid_i && host_enable_i;
  assign advance = expired_i && host_enable_i;

  // ====================
  // Command latch
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stop_q     <= 1'b0;
      is_addr_q  <= 1'b0;
      use_tbit_q <= 1'b0;
    end else if (accept) begin
      stop_q     <= tx_stop_i;
      is_addr_q  <= tx_is_addr_i;
      use_tbit_q <= tx_use_tbit_i;
    end
  end

  // ====================
  // Next state
  // ====================
  always_comb begin
    state_d = state_q;
    if (accept) begin
      if (tx_start_i) begin
        state_d = setup_start;
      end else if (tx_sr_i) begin
        state_d = setup_sr;
      end else begin
        state_d = clock_low;  // Continue an open transfer
      end
    end else if (advance) begin
      case (state_q)
        setup_start: state_d = hold_start;
        hold_start:  state_d = clock_start;
        clock_start: state_d = clock_low;
        setup_sr:    state_d = hold_sr;
        hold_sr:     state_d = fall_sr;
        fall_sr:     state_d = clock_sr;
        clock_sr:    state_d = clock_low;
        clock_low:   state_d = clock_pulse;
        clock_pulse: state_d = hold_bit;
        hold_bit:    state_d = last_bit_i ? ack_low : clock_low;
        ack_low:     state_d = ack_pulse;
        ack_pulse:   state_d = ack_hold;
        ack_hold:    state_d = stop_q ? setup_stop : idle;
        setup_stop:  state_d = rise_stop;
        rise_stop:   state_d = hold_stop;
        default:     state_d = idle;  // hold_stop, idle stays put
      endcase
    end
  end

  // Delay of the entered state; every transition reloads the timer
  always_comb begin
    case (state_d)
      setup_start, setup_sr, hold_sr:   phase_sel_o = ph_setup_start;
      hold_start, fall_sr:              phase_sel_o = ph_hold_start;
      clock_pulse, ack_pulse:           phase_sel_o = ph_clock_pulse;
      hold_bit, ack_hold:               phase_sel_o = ph_hold_bit;
      rise_stop:                        phase_sel_o = ph_setup_stop;
      hold_stop:                        phase_sel_o = ph_hold_stop;
      idle:                             phase_sel_o = ph_no_delay;
      default:                          phase_sel_o = ph_clock_low;  // SCL low states
    endcase
  end

  assign load_o       = (state_d != state_q);
  assign load_byte_o  = accept;
  assign bit_next_o   = advance && (state_q == hold_bit) && !last_bit_i;
  assign sample_ack_o = advance && (state_q == ack_pulse) && is_addr_q;  // SCL falling

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  // ====================
  // Bus and status
  // ====================
  // Address: release for ACK. Data: T-bit low, else released
  assign ninth_sda = is_addr_q || !use_tbit_q;

  assign scl_o = !(state_q inside {clock_start, setup_sr, clock_sr, clock_low, hold_bit,
                                   ack_low, ack_hold, setup_stop});

  always_comb begin
    case (state_q)
      hold_start, clock_start, fall_sr, clock_sr,
      ack_hold, setup_stop, rise_stop:     sda_o = 1'b0;
      clock_low, clock_pulse, hold_bit:    sda_o = data_bit_i;
      ack_low, ack_pulse:                  sda_o = ninth_sda;
      default:                             sda_o = 1'b1;  // Released
    endcase
  end

  assign host_idle_o = (state_q == idle);
  assign tx_ready_o  = host_idle_o && host_enable_i;
  assign tx_done_o   = (state_q == ack_hold) && advance;
  assign rx_ack_o    = tx_done_o && is_addr_q && ack_seen_i;
  assign rx_nack_o   = tx_done_o && is_addr_q && !ack_seen_i;

  // Only START, Sr and STOP may move SDA under a high SCL
  a_sda_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (scl_o && $past(scl_o) && $changed(sda_o)) |-> state_q inside {hold_start, fall_sr,
                                                                   hold_stop});

endmodule

//--- flist.f
i3c_timing_pkg.sv
i3c_bus_pkg.sv
scl_timer.sv
tx_shifter.sv
bus_sequencer.sv
i3c_controller.sv
tb_i3c_controller.sv

//--- i3c_bus_pkg.sv
// I3C bus definitions: byte and bit-index widths and the sequencer states
package i3c_bus_pkg;

  localparam int byte_w    = 8;  // Payload byte
  localparam int bit_idx_w = 4;  // Counts 8 down to 0

  // ====================
  // Sequencer states
  // ====================
  typedef enum logic [4:0] {
    idle,                                      // Bus released, waiting for a byte
    setup_start, hold_start, clock_start,      // START condition
    setup_sr, hold_sr, fall_sr, clock_sr,      // Repeated Start
    clock_low, clock_pulse, hold_bit,          // One data bit
    ack_low, ack_pulse, ack_hold,              // Ninth bit, ACK or T-bit
    setup_stop, rise_stop, hold_stop           // STOP condition
  } seq_state_e;

endpackage

//--- i3c_controller.sv
// I3C/I2C single-byte transmit controller: timer, shifter and sequencer
`timescale 1ns/1ps

module i3c_controller #(
  parameter int SYS_CLK_MHZ = 100  // System clock, 100, 200 or 400
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 scl_i,
  input  logic                                 sda_i,
  output logic                                 scl_o,
  output logic                                 sda_o,
  input  logic                                 push_pull_i,
  input  i3c_timing_pkg::sdr_mode_e            mode_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  t_r_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  t_f_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  thigh_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tlow_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  thd_sta_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tsu_sta_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tsu_sto_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tsu_dat_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  thd_dat_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  t_buf_i,
  input  logic                                 host_enable_i,
  output logic                                 host_idle_o,
  input  logic                                 tx_valid_i,
  input  logic [i3c_bus_pkg::byte_w-1:0]       tx_data_i,
  input  logic                                 tx_start_i,
  input  logic                                 tx_stop_i,
  input  logic                                 tx_sr_i,
  input  logic                                 tx_is_addr_i,
  input  logic                                 tx_use_tbit_i,
  output logic                                 tx_ready_o,
  output logic                                 tx_done_o,
  output logic                                 rx_ack_o,
  output logic                                 rx_nack_o
);
  import i3c_timing_pkg::*;

  logic       load;        // Sequencer to timer
  phase_sel_e phase_sel;
  logic       expired;
  logic       load_byte;   // Sequencer to shifter
  logic       bit_next;
  logic       sample_ack;
  logic       data_bit;
  logic       last_bit;
  logic       ack_seen;

  scl_timer #(
    .SYS_CLK_MHZ (SYS_CLK_MHZ)
  ) u_scl_timer (
    .clk_i, .rst_ni, .push_pull_i, .mode_i,
    .t_r_i, .t_f_i, .thigh_i, .tlow_i, .thd_sta_i,
    .tsu_sta_i, .tsu_sto_i, .tsu_dat_i, .thd_dat_i, .t_buf_i,
    .host_enable_i,
    .load_i      (load),
    .phase_sel_i (phase_sel),
    .expired_o   (expired)
  );

  tx_shifter u_tx_shifter (
    .clk_i, .rst_ni, .tx_data_i, .sda_i,
    .load_byte_i  (load_byte),
    .bit_next_i   (bit_next),
    .sample_ack_i (sample_ack),
    .data_bit_o   (data_bit),
    .last_bit_o   (last_bit),
    .ack_seen_o   (ack_seen)
  );

  bus_sequencer u_bus_sequencer (
    .clk_i, .rst_ni, .host_enable_i,
    .tx_valid_i, .tx_start_i, .tx_stop_i, .tx_sr_i, .tx_is_addr_i, .tx_use_tbit_i,
    .expired_i    (expired),
    .data_bit_i   (data_bit),
    .last_bit_i   (last_bit),
    .ack_seen_i   (ack_seen),
    .load_o       (load),
    .phase_sel_o  (phase_sel),
    .load_byte_o  (load_byte),
    .bit_next_o   (bit_next),
    .sample_ack_o (sample_ack),
    .scl_o, .sda_o, .host_idle_o, .tx_ready_o, .tx_done_o, .rx_ack_o, .rx_nack_o
  );

  // Wired-AND bus, SCL cannot read high while the controller pulls it low
  a_scl_wired_and: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !scl_o |-> !scl_i);

endmodule

//--- i3c_timing_pkg.sv
// I3C timing definitions: timer widths, phase selection and SDR speed modes
package i3c_timing_pkg;

  // ====================
  // Widths
  // ====================
  localparam int timing_w      = 20;  // OD timing CSRs and phase counter
  localparam int half_period_w = 8;   // PP half-period from the table

  // SDR speed modes, index into the half-period table
  typedef enum logic [2:0] {
    sdr0,  // 12.5 MHz
    sdr1,  // ~8 MHz
    sdr2,  // ~6 MHz
    sdr3,  // ~4 MHz
    sdr4   // 2 MHz
  } sdr_mode_e;

  // Delay the timer loads on a phase change
  typedef enum logic [3:0] {
    ph_setup_start,  // START/Sr setup, both lines high
    ph_hold_start,   // START/Sr hold, SDA low under high SCL
    ph_setup_data,   // Data setup before SCL rise
    ph_clock_low,    // SCL low time
    ph_clock_pulse,  // SCL high time
    ph_hold_bit,     // Data hold after SCL fall
    ph_setup_stop,   // STOP setup, SCL high and SDA low
    ph_hold_stop,    // Bus free after STOP
    ph_no_delay      // Single cycle
  } phase_sel_e;

endpackage

//--- scl_timer.sv
// SCL phase timer: picks the OD or PP delay for a phase and counts it down
`timescale 1ns/1ps

module scl_timer #(
  parameter int SYS_CLK_MHZ = 100  // Selects the PP table row
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  input  logic                                 push_pull_i,  // 0 = OD timing, 1 = PP timing
  input  i3c_timing_pkg::sdr_mode_e            mode_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  t_r_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  t_f_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  thigh_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tlow_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  thd_sta_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tsu_sta_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tsu_sto_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  tsu_dat_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  thd_dat_i,
  input  logic [i3c_timing_pkg::timing_w-1:0]  t_buf_i,
  input  logic                                 host_enable_i,  // Low freezes the count
  input  logic                                 load_i,
  input  i3c_timing_pkg::phase_sel_e           phase_sel_i,
  output logic                                 expired_o       // Last cycle of the phase
);
  import i3c_timing_pkg::*;

  logic [half_period_w-1:0] half_period;  // H for the current mode
  logic [timing_w-1:0]      load_val;
  logic [timing_w-1:0]      count_q;

  // ====================
  // PP half-period table
  // ====================
  // H = ceil(f_sys / (2 * f_scl)); unknown clocks use the 100 MHz row
  always_comb begin
    case (SYS_CLK_MHZ)
      200: begin
        case (mode_i)
          sdr0:    half_period = 8'd8;
          sdr1:    half_period = 8'd13;
          sdr2:    half_period = 8'd17;
          sdr3:    half_period = 8'd25;
          default: half_period = 8'd50;  // sdr4 and illegal codes
        endcase
      end
      400: begin
        case (mode_i)
          sdr0:    half_period = 8'd16;
          sdr1:    half_period = 8'd25;
          sdr2:    half_period = 8'd34;
          sdr3:    half_period = 8'd50;
          default: half_period = 8'd100;
        endcase
      end
      default: begin
        case (mode_i)
          sdr0:    half_period = 8'd4;
          sdr1:    half_period = 8'd7;
          sdr2:    half_period = 8'd9;
          sdr3:    half_period = 8'd13;
          default: half_period = 8'd25;
        endcase
      end
    endcase
  end

  // Delay for the requested phase
  always_comb begin
    if (push_pull_i) begin
      // 50% duty SCL, START/STOP edges at a quarter period
      case (phase_sel_i)
        ph_setup_start, ph_hold_start,
        ph_setup_stop, ph_hold_stop:   load_val = timing_w'(half_period >> 1);
        ph_setup_data, ph_hold_bit:    load_val = timing_w'(2);
        ph_clock_low, ph_clock_pulse:  load_val = timing_w'(half_period);
        default:                       load_val = timing_w'(1);
      endcase
    end else begin
      case (phase_sel_i)
        ph_setup_start: load_val = t_r_i + tsu_sta_i;
        ph_hold_start:  load_val = t_f_i + thd_sta_i;
        ph_setup_data:  load_val = t_r_i + tsu_dat_i;
        ph_clock_low:   load_val = tlow_i - thd_dat_i;  // Hold time is spent in hold_bit
        ph_clock_pulse: load_val = t_r_i + thigh_i;
        ph_hold_bit:    load_val = t_f_i + thd_dat_i;
        ph_setup_stop:  load_val = t_r_i + tsu_sto_i;
        ph_hold_stop:   load_val = t_r_i + t_buf_i - tsu_sta_i;
        default:        load_val = timing_w'(1);
      endcase
    end
  end

  // ====================
  // Phase down-counter
  // ====================
  // Value N lasts N enabled cycles, parks at 1
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= timing_w'(1);
    end else if (load_i) begin
      count_q <= load_val;
    end else if (host_enable_i && (count_q > timing_w'(1))) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign expired_o = (count_q == timing_w'(1));

  // A zero delay from the CSRs would hang the sequencer
  a_count_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q != '0);

endmodule

//--- tb_i3c_controller.sv
// Testbench for the I3C transmit controller: target model, bus monitor and directed tests
`timescale 1ns/1ps

module tb_i3c_controller;
  import i3c_timing_pkg::*;

  logic clk_i = 1'b0, rst_ni, scl_i, sda_i, scl_o, sda_o, push_pull_i, host_enable_i;
  sdr_mode_e mode_i;
  logic [timing_w-1:0] t_r_i, t_f_i, thigh_i, tlow_i, thd_sta_i;
  logic [timing_w-1:0] tsu_sta_i, tsu_sto_i, tsu_dat_i, thd_dat_i, t_buf_i;
  logic host_idle_o, tx_valid_i, tx_start_i, tx_stop_i, tx_sr_i, tx_is_addr_i, tx_use_tbit_i;
  logic [7:0] tx_data_i;
  logic tx_ready_o, tx_done_o, rx_ack_o, rx_nack_o;
  logic ack_pull = 1'b1;                // Target pull on SDA, low = ACK

  logic [7:0] exp_byte, rx_byte;
  logic exp_is_addr = 1'b0, want_ack = 1'b0, exp_ninth = 1'b1;
  logic scl_p = 1'b1, sda_p = 1'b1, measuring = 1'b0;
  logic in_flight;                      // Byte accepted, tx_done_o not yet seen
  int bit_cnt = 0, hi_len = 0, start_cnt = 0, stop_cnt = 0;
  int bytes_sent = 0, bytes_seen = 0, errors = 0, tests = 0, test_err = 0;
  string cur_test = "reset";

  always #2 clk_i = ~clk_i;  // 4 ns period

  assign sda_i = sda_o & ack_pull;  // Wired-AND bus
  assign scl_i = scl_o;

  i3c_controller #(.SYS_CLK_MHZ(100)) dut0 (.*);

  // PP half-period, 100 MHz row
  function automatic int half_period(sdr_mode_e m);
    case (m)
      sdr0:    return 4;
      sdr1:    return 7;
      sdr2:    return 9;
      sdr3:    return 13;
      default: return 25;
    endcase
  endfunction

  task automatic check_eq(string what, int exp_v, int act_v);
    assert (exp_v == act_v) else begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h actual %0h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic end_run();
    $display("tests %0d, bytes %0d/%0d, errors %0d", tests, bytes_seen, bytes_sent, errors);
    if (errors == 0 && bytes_seen == bytes_sent) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic report_timeout(string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  task automatic finish_test();
    tests++;
    $display("test %s done, %0d errors", cur_test, errors - test_err);
    test_err = errors;
  endtask

  // ====================
  // Bus monitor
  // ====================
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (scl_i && scl_p && sda_p && !sda_o) begin  // START or Sr
        start_cnt++;
        bit_cnt   = 0;
        measuring = 1'b0;
      end else if (scl_i && scl_p && !sda_p && sda_o) begin  // STOP
        stop_cnt++;
        bit_cnt   = 0;
        measuring = 1'b0;
      end
      if (scl_i && !scl_p && !host_idle_o) begin
        measuring = 1'b1;
        hi_len    = host_enable_i ? 1 : 0;
        if (bit_cnt < 8) begin
          rx_byte = {rx_byte[6:0], sda_o};
          bit_cnt++;
        end else begin
          bit_cnt = 0;
          bytes_seen++;
          check_eq("byte", exp_byte, rx_byte);
          if (!exp_is_addr) check_eq("ninth bit", exp_ninth, sda_o);
          if (exp_is_addr && want_ack) ack_pull <= 1'b0;
        end
      end else if (scl_i && host_enable_i) begin
        hi_len++;
      end
      if (!scl_i && scl_p) begin
        ack_pull <= 1'b1;
        if (measuring) check_eq("scl high", push_pull_i ? half_period(mode_i)
                                                        : t_r_i + thigh_i, hi_len);
        measuring = 1'b0;
      end
    end
    scl_p = scl_i;
    sda_p = sda_o;
  end

  // Byte in flight from acceptance to its tx_done_o pulse
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight <= 1'b0;
    end else if (tx_done_o) begin
      in_flight <= 1'b0;
    end else if (tx_valid_i && tx_ready_o) begin
      in_flight <= 1'b1;
    end
  end

  a_ack_status: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_done_o |-> (exp_is_addr ? (rx_ack_o == want_ack && rx_nack_o == !want_ack)
                               : (!rx_ack_o && !rx_nack_o)))
    else begin
      errors++;
      $display("CHECK FAILED %s ack/nack: expected %02b actual %02b", cur_test,
               exp_is_addr ? {want_ack, !want_ack} : 2'b00, {rx_ack_o, rx_nack_o});
    end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_done_o |=> !tx_done_o)
    else begin
      errors++;
      $display("%s: tx_done_o stayed high for more than one cycle", cur_test);
    end

  // Stall freezes the bus lines
  a_stall_freeze: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!host_enable_i && $past(!host_enable_i)) |-> ($stable(scl_o) && $stable(sda_o)))
    else begin
      errors++;
      $display("%s: bus lines moved during a stall", cur_test);
    end

  // No new byte while one is on the bus or the host holds off
  a_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_flight || !host_enable_i) |-> !tx_ready_o)
    else begin
      errors++;
      $display("%s: tx_ready_o high while a byte is busy or the host is disabled", cur_test);
    end

  // Hand one byte over and wait for its tx_done_o pulse
  task automatic send_byte(logic [7:0] data, logic start, logic stop, logic sr,
                           logic is_addr, logic tbit, logic ack);
    int n;
    n           = 0;
    exp_byte    = data;
    exp_is_addr = is_addr;
    want_ack    = ack;
    exp_ninth   = !tbit;
    bytes_sent++;
    tx_valid_i <= 1'b1;
    tx_data_i <= data;
    tx_start_i <= start;
    tx_stop_i <= stop;
    tx_sr_i <= sr;
    tx_is_addr_i <= is_addr;
    tx_use_tbit_i <= tbit;
    do begin
      @(posedge clk_i);
      n++;
    end while (!tx_ready_o && n < 200);
    if (!tx_ready_o) report_timeout("byte never accepted");
    tx_valid_i <= 1'b0;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!tx_done_o && n < 3000);
    if (!tx_done_o) report_timeout("timeout waiting for tx_done_o");
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!host_idle_o && n < 500);
    if (!host_idle_o) report_timeout("bus never returned to idle");
  endtask

  initial begin
    int s0, p0;
    int n;
    void'($urandom(32'hf1b6_15bf));
    rst_ni = 1'b0;
    push_pull_i = 1'b0;
    mode_i = sdr0;
    host_enable_i = 1'b1;
    {tx_valid_i, tx_start_i, tx_stop_i, tx_sr_i, tx_is_addr_i, tx_use_tbit_i} = '0;
    tx_data_i = '0;
    t_r_i = 2;
    t_f_i = 2;
    thigh_i = 6;
    tlow_i = 8;
    thd_sta_i = 4;
    tsu_sta_i = 4;
    tsu_sto_i = 4;
    tsu_dat_i = 2;
    thd_dat_i = 2;
    t_buf_i = 8;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    @(posedge clk_i);
    check_eq("scl", 1, scl_o);
    check_eq("sda", 1, sda_o);
    check_eq("idle", 1, host_idle_o);
    check_eq("done/ack/nack", 0, {tx_done_o, rx_ack_o, rx_nack_o});
    check_eq("ready", host_enable_i, tx_ready_o);
    finish_test();

    // ==================== Open-drain frame
    cur_test = "od_start_data_stop";
    s0 = start_cnt;
    p0 = stop_cnt;
    send_byte(8'($urandom), 1, 1, 0, 0, 0, 0);
    wait_idle();
    check_eq("starts", s0 + 1, start_cnt);
    check_eq("stops", p0 + 1, stop_cnt);
    finish_test();

    cur_test = "addr_ack_nack";
    send_byte(8'($urandom), 1, 1, 0, 1, 0, 1);
    wait_idle();
    send_byte(8'($urandom), 1, 1, 0, 1, 0, 0);
    wait_idle();
    finish_test();

    // ==================== Push-pull periods
    cur_test = "pp_period";
    push_pull_i <= 1'b1;
    send_byte(8'($urandom), 1, 1, 0, 0, 0, 0);
    wait_idle();
    mode_i <= sdr4;
    send_byte(8'($urandom), 1, 1, 0, 0, 0, 0);
    wait_idle();
    finish_test();

    cur_test = "tbit_sr";
    mode_i <= sdr0;
    s0 = start_cnt;
    p0 = stop_cnt;
    send_byte(8'($urandom), 1, 0, 0, 0, 1, 0);
    send_byte(8'($urandom), 0, 1, 1, 0, 0, 0);
    check_eq("stops between", p0, stop_cnt);
    check_eq("starts", s0 + 2, start_cnt);
    wait_idle();
    finish_test();

    // ==================== Back-pressure
    cur_test = "stall";
    push_pull_i <= 1'b0;
    fork
      send_byte(8'($urandom), 1, 1, 0, 0, 0, 0);
      begin
        n = 0;
        while (bit_cnt != 3 && n < 1000) begin
          @(posedge clk_i);
          n++;
        end
        if (bit_cnt != 3) report_timeout("stall point never reached");
        host_enable_i <= 1'b0;
        repeat (12) @(posedge clk_i);
        host_enable_i <= 1'b1;
      end
    join
    wait_idle();
    finish_test();
    end_run();
  end

endmodule

//--- tx_shifter.sv
// Transmit byte holder: presents the current SDA data bit and samples the target ACK
`timescale 1ns/1ps

module tx_shifter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [i3c_bus_pkg::byte_w-1:0]   tx_data_i,
  input  logic                             sda_i,          // Bus SDA readback
  input  logic                             load_byte_i,    // Capture byte, index to 8
  input  logic                             bit_next_i,     // Move to next lower bit
  input  logic                             sample_ack_i,
  output logic                             data_bit_o,     // Bit at index - 1
  output logic                             last_bit_o,     // Index at 1, bit 0 on the bus
  output logic                             ack_seen_o      // Target pulled SDA low
);
  import i3c_bus_pkg::*;

  logic [byte_w-1:0]    byte_q;   // Payload
  logic [bit_idx_w-1:0] idx_q;
  logic [bit_idx_w-1:0] idx_m1;
  logic                 ack_q;    // Sampled SDA, 1 = NACK

  always_ff @(posedge clk_i) begin
    if (load_byte_i) begin
      byte_q <= tx_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_q <= bit_idx_w'(byte_w);
    end else if (load_byte_i) begin
      idx_q <= bit_idx_w'(byte_w);  // MSB first
    end else if (bit_next_i) begin
      idx_q <= idx_q - 1'b1;
    end
  end

  // Released SDA reads high, so NACK until sampled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b1;
    end else if (sample_ack_i) begin
      ack_q <= sda_i;
    end
  end

  assign idx_m1     = idx_q - 1'b1;
  assign data_bit_o = byte_q[idx_m1[$clog2(byte_w)-1:0]];
  assign last_bit_o = (idx_q == bit_idx_w'(1));
  assign ack_seen_o = ~ack_q;

  // Sequencer leaves for the ninth bit at index 1
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bit_next_i |-> idx_q != '0);

endmodule
